/* src/core_pkg.sv */
package core_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // operand a source
    typedef enum logic {
        SRC_RS1,
        SRC_PC
    } src_a_e;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_sel_e;

endpackage

/* src/decode_if.sv */
`timescale 1ns/10ps

interface decode_if;

    logic [core_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_pkg::REG_ADDR_W-1:0] rs2;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::XLEN-1:0]       imm;
    core_pkg::alu_op_e               alu_op;
    core_pkg::src_a_e                src_a;
    logic                            use_imm;
    logic                            rd_we;
    core_pkg::wb_sel_e               wb_sel;
    logic                            is_branch;
    logic [2:0]                      branch_funct3;
    logic                            is_jal;
    logic                            is_jalr;
    logic                            mem_read;
    logic                            mem_write;
    logic                            is_halt;

    modport idu (
        output rs1, rs2, rd, imm, alu_op, src_a, use_imm, rd_we, wb_sel,
               is_branch, branch_funct3, is_jal, is_jalr, mem_read, mem_write, is_halt
    );

    modport exu (
        input imm, alu_op, src_a, use_imm, is_branch, branch_funct3,
              is_jal, is_jalr, mem_read, mem_write
    );

    modport wbu (
        input rd, rd_we, wb_sel
    );

endinterface

/* src/riscv_ifu.sv */
`timescale 1ns/10ps

module riscv_ifu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [core_pkg::XLEN-1:0] next_pc,
    input  logic                      halt_req,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      halted
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= core_pkg::RESET_PC;
            halted <= 1'b0;
        end else begin
            // pc freezes once the core has stopped
            if (!halted) begin
                pc <= next_pc;
            end
            // sticky until the next reset
            if (halt_req) begin
                halted <= 1'b1;
            end
        end
    end

    // next_pc comes from the exu, so a bad jump target shows up here
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

/* src/riscv_idu.sv */
`timescale 1ns/10ps

module riscv_idu (
    input  logic [core_pkg::XLEN-1:0] inst,
    decode_if.idu                     dec
);

    core_pkg::opcode_e         opcode;
    logic [2:0]                funct3;
    logic                      funct7_b5;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;
    core_pkg::alu_op_e         arith_op;

    assign opcode    = core_pkg::opcode_e'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];

    // immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3/funct7 to alu op for both OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == core_pkg::OP && funct7_b5) ?
                                core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  arith_op = core_pkg::ALU_SLL;
            3'b010:  arith_op = core_pkg::ALU_SLT;
            3'b011:  arith_op = core_pkg::ALU_SLTU;
            3'b100:  arith_op = core_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  arith_op = core_pkg::ALU_OR;
            default: arith_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec.rs1           = inst[19:15];
        dec.rs2           = inst[24:20];
        dec.rd            = inst[11:7];
        dec.imm           = imm_i;
        dec.alu_op        = core_pkg::ALU_ADD;
        dec.src_a         = core_pkg::SRC_RS1;
        dec.use_imm       = 1'b1;
        dec.rd_we         = 1'b0;
        dec.wb_sel        = core_pkg::WB_ALU;
        dec.is_branch     = 1'b0;
        dec.branch_funct3 = funct3;
        dec.is_jal        = 1'b0;
        dec.is_jalr       = 1'b0;
        dec.mem_read      = 1'b0;
        dec.mem_write     = 1'b0;
        dec.is_halt       = 1'b0;

        case (opcode)
            core_pkg::OP: begin
                dec.alu_op  = arith_op;
                dec.use_imm = 1'b0;
                dec.rd_we   = 1'b1;
            end
            core_pkg::OP_IMM: begin
                dec.alu_op = arith_op;
                dec.rd_we  = 1'b1;
            end
            core_pkg::LUI: begin
                dec.imm    = imm_u;
                dec.alu_op = core_pkg::ALU_PASS_B;
                dec.rd_we  = 1'b1;
            end
            core_pkg::AUIPC: begin
                dec.imm   = imm_u;
                dec.src_a = core_pkg::SRC_PC;
                dec.rd_we = 1'b1;
            end
            core_pkg::BRANCH: begin
                // compare and target both handled in the exu
                dec.imm       = imm_b;
                dec.use_imm   = 1'b0;
                dec.is_branch = 1'b1;
            end
            core_pkg::JAL: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.rd_we  = 1'b1;
                dec.wb_sel = core_pkg::WB_LINK;
            end
            core_pkg::JALR: begin
                dec.is_jalr = 1'b1;
                dec.rd_we   = 1'b1;
                dec.wb_sel  = core_pkg::WB_LINK;
            end
            core_pkg::LOAD: begin
                // word access only
                if (funct3 == 3'b010) begin
                    dec.mem_read = 1'b1;
                    dec.rd_we    = 1'b1;
                    dec.wb_sel   = core_pkg::WB_LOAD;
                end
            end
            core_pkg::STORE: begin
                dec.imm = imm_s;
                if (funct3 == 3'b010) begin
                    dec.mem_write = 1'b1;
                end
            end
            core_pkg::SYSTEM: begin
                // ebreak only
                dec.is_halt = (inst == 32'h0010_0073);
            end
            default: begin
            end
        endcase
    end

endmodule

/* src/riscv_regfile.sv */
`timescale 1ns/10ps

module riscv_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pkg::XLEN-1:0]       rs2_data,
    input  logic                            rd_we,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd_addr,
    input  logic [core_pkg::XLEN-1:0]       rd_data
);

    logic [core_pkg::XLEN-1:0] regs [0:(1 << core_pkg::REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << core_pkg::REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* src/riscv_exu.sv */
`timescale 1ns/10ps

module riscv_exu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [core_pkg::XLEN-1:0] rs1_data,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic                      halted,
    decode_if.exu                     dec,
    output logic [core_pkg::XLEN-1:0] alu_result,
    output logic [core_pkg::XLEN-1:0] next_pc,
    output logic                      mem_we
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [4:0]                shamt;
    logic                      cond;
    logic                      branch_taken;

    assign op_a  = (dec.src_a == core_pkg::SRC_PC) ? pc : rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            core_pkg::ALU_SUB:    alu_result = op_a - op_b;
            core_pkg::ALU_AND:    alu_result = op_a & op_b;
            core_pkg::ALU_OR:     alu_result = op_a | op_b;
            core_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            core_pkg::ALU_SLT:    alu_result = {{(core_pkg::XLEN-1){1'b0}},
                                                $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU:   alu_result = {{(core_pkg::XLEN-1){1'b0}}, op_a < op_b};
            core_pkg::ALU_SLL:    alu_result = op_a << shamt;
            core_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            core_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_PASS_B: alu_result = op_b;
            default:              alu_result = op_a + op_b;
        endcase
    end

    // branch condition on the raw register operands
    always_comb begin
        case (dec.branch_funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = dec.is_branch && cond;

    // jalr target is the alu sum rs1 + imm with bit 0 dropped
    always_comb begin
        if (branch_taken || dec.is_jal) begin
            next_pc = pc + dec.imm;
        end else if (dec.is_jalr) begin
            next_pc = {alu_result[core_pkg::XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // no stores once the core has stopped
    assign mem_we = dec.mem_write && !halted;

    assert property (@(posedge clk) disable iff (!rst_n)
        (!halted && (dec.mem_read || dec.mem_write)) |-> alu_result[1:0] == 2'b00)
        else $error("misaligned data access at %h", alu_result);

endmodule

/* src/riscv_wbu.sv */
`timescale 1ns/10ps

module riscv_wbu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [core_pkg::XLEN-1:0]       alu_result,
    input  logic [core_pkg::XLEN-1:0]       load_data,
    input  logic [core_pkg::XLEN-1:0]       pc,
    decode_if.wbu                           dec,
    input  logic                            halted,
    output logic                            rd_we,
    output logic [core_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [core_pkg::XLEN-1:0]       rd_data
);

    assign rd_we   = dec.rd_we && !halted;
    assign rd_addr = dec.rd;

    always_comb begin
        case (dec.wb_sel)
            core_pkg::WB_LOAD: rd_data = load_data;
            // return address for jal/jalr
            core_pkg::WB_LINK: rd_data = pc + 32'd4;
            default:           rd_data = alu_result;
        endcase
    end

    // halt is sticky and keeps the register file frozen
    assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted && !rd_we)
        else $error("register write after halt");

endmodule

/* src/riscv_core.sv */
`timescale 1ns/10ps

module riscv_core (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    input  logic [core_pkg::XLEN-1:0] imem_rdata,
    output logic [core_pkg::XLEN-1:0] dmem_addr,
    output logic [core_pkg::XLEN-1:0] dmem_wdata,
    output logic                      dmem_we,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata,
    output logic                      halted
);

    logic [core_pkg::XLEN-1:0]       pc;
    logic [core_pkg::XLEN-1:0]       next_pc;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;
    logic [core_pkg::XLEN-1:0]       alu_result;
    logic                            rd_we;
    logic [core_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [core_pkg::XLEN-1:0]       rd_data;

    decode_if dec_bus ();

    riscv_ifu u_ifu (
        .clk      (clk),
        .rst_n    (rst_n),
        .next_pc  (next_pc),
        .halt_req (dec_bus.is_halt),
        .pc       (pc),
        .halted   (halted)
    );

    riscv_idu u_idu (
        .inst (imem_rdata),
        .dec  (dec_bus.idu)
    );

    riscv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (dec_bus.rs1),
        .rs2_addr (dec_bus.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_we    (rd_we),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    riscv_exu u_exu (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .halted     (halted),
        .dec        (dec_bus.exu),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .mem_we     (dmem_we)
    );

    riscv_wbu u_wbu (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_result (alu_result),
        .load_data  (dmem_rdata),
        .pc         (pc),
        .dec        (dec_bus.wbu),
        .halted     (halted),
        .rd_we      (rd_we),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // memory side
    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;

endmodule

/* verification/core_tb.sv */
`timescale 1ns/10ps

module core_tb;

    localparam int          MEM_WORDS   = 256;
    localparam int          RUN_BUDGET  = 200;
    localparam int          RUNS        = 7;
    localparam int          WATCHDOG_NS = RUNS * (RUN_BUDGET + 20) * 40 + 2000;
    localparam logic [31:0] EBREAK      = 32'h0010_0073;
    localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD    = 7'b0000011;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        halted;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_what [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] lfsr_state;
    int          next_slot;
    int          errors;
    int          checks;

    riscv_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    function automatic logic [7:0] mem_index(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - core_pkg::RESET_PC;
        return offset[9:2];
    endfunction

    // fill value mixes every address bit
    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] addr;
        addr = core_pkg::RESET_PC + 32'(idx * 4);
        return {addr[15:0], addr[31:16]} ^ 32'h6b1d_c3a5;
    endfunction

    // combinational memories based at the reset pc
    assign imem_rdata = imem[mem_index(imem_addr)];
    assign dmem_rdata = dmem[mem_index(dmem_addr)];

    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            dmem[mem_index(dmem_addr)] <= dmem_wdata;
            got_addr.push_back(dmem_addr);
            got_data.push_back(dmem_wdata);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // rv32i integer op result with alt selecting sub or sra
    function automatic logic [31:0] alu_ref(input int f3, input bit alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            0: r = alt ? a - b : a + b;
            1: r = a << b[4:0];
            2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: r = (a < b) ? 32'd1 : 32'd0;
            4: r = a ^ b;
            5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic bit branch_ref(input int f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] cur_addr();
        return core_pkg::RESET_PC + 32'(prog.size() * 4);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // lui + addi with the upper part rounded up for a negative low half
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(u_type(hi[31:12], rd, 7'b0110111));
        emit(i_type(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    task automatic store_at(input logic [4:0] rs, input int off, input logic [31:0] value,
                            input string what);
        emit(s_type(12'(off), rs, 5'd31));
        exp_addr.push_back(core_pkg::RESET_PC + 32'(off));
        exp_data.push_back(value);
        exp_what.push_back(what);
    endtask

    task automatic store_slot(input logic [4:0] rs, input logic [31:0] value,
                              input string what);
        store_at(rs, next_slot * 4, value, what);
        next_slot++;
    endtask

    // x31 holds the data base for every program
    task automatic start_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_what.delete();
        next_slot = 0;
        emit(u_type(core_pkg::RESET_PC[31:12], 5'd31, 7'b0110111));
    endtask

    task automatic load_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : EBREAK;
            dmem[i] <= fill_word(i);
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        int stores_at_halt;
        int n;
        emit(EBREAK);
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        load_memories();
        got_addr.delete();
        got_data.delete();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        checks++;
        if (halted !== 1'b0 || imem_addr !== core_pkg::RESET_PC) begin
            errors++;
            $display("ERROR at %0t: %s: after reset halted=%b imem_addr=%h", $time, name,
                     halted, imem_addr);
        end
        cycles = 0;
        while (halted !== 1'b1 && cycles < RUN_BUDGET) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        checks++;
        if (halted !== 1'b1) begin
            errors++;
            $display("%s: the core did not halt within %0d cycles", name, RUN_BUDGET);
        end else begin
            stores_at_halt = got_addr.size();
            repeat (10) begin
                @(posedge clk);
                #2;
                checks++;
                if (halted !== 1'b1) begin
                    errors++;
                    $display("ERROR at %0t: %s: halted dropped without reset", $time, name);
                end
            end
            checks++;
            if (got_addr.size() != stores_at_halt) begin
                errors++;
                $display("%s: the core stored to memory after it halted", name);
            end
        end
        checks++;
        if (got_addr.size() != exp_addr.size()) begin
            errors++;
            $display("ERROR at %0t: %s: %0d stores seen, %0d expected", $time, name,
                     got_addr.size(), exp_addr.size());
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            checks++;
            if (got_addr[i] !== exp_addr[i] || got_data[i] !== exp_data[i]) begin
                errors++;
                $display("ERROR at %0t: %s: %s stored %h at %h, expected %h at %h", $time,
                         name, exp_what[i], got_data[i], got_addr[i], exp_data[i], exp_addr[i]);
            end
        end
    endtask

    task automatic arithmetic_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        start_program();
        for (int set = 0; set < 2; set++) begin
            a = lfsr_bits(32);
            b = lfsr_bits(32);
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 0 || f3 == 0 || f3 == 5) begin
                        emit(r_type((alt != 0) ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1,
                                    3'(f3), 5'd3));
                        store_slot(5'd3, alu_ref(f3, alt != 0, a, b),
                                   $sformatf("reg op f3=%0d alt=%0d", f3, alt));
                    end
                    if (alt == 0 || f3 == 5) begin
                        if (f3 == 1 || f3 == 5) begin
                            // bit 10 of the shift immediate picks srai
                            imm = lfsr_bits(5);
                            imm[10] = (alt != 0);
                        end else begin
                            imm = lfsr_bits(12);
                            imm = {{20{imm[11]}}, imm[11:0]};
                        end
                        emit(i_type(imm[11:0], 5'd1, 3'(f3), 5'd4, OPC_OP_IMM));
                        store_slot(5'd4, alu_ref(f3, alt != 0, a, imm),
                                   $sformatf("imm op f3=%0d alt=%0d", f3, alt));
                    end
                end
            end
        end
        run_program("arithmetic");
    endtask

    task automatic branch_paths();
        logic [31:0] pair_a [3];
        logic [31:0] pair_b [3];
        bit          taken;
        pair_a = '{32'd5, 32'd5, 32'hffff_fffd};
        pair_b = '{32'd5, 32'hffff_fffd, 32'd5};
        start_program();
        for (int p = 0; p < 3; p++) begin
            load_const(5'd1, pair_a[p]);
            load_const(5'd2, pair_b[p]);
            for (int k = 0; k < 8; k++) begin
                if (k != 2 && k != 3) begin
                    taken = branch_ref(k, pair_a[p], pair_b[p]);
                    emit(b_type(13'd12, 5'd2, 5'd1, 3'(k)));
                    // x3 is 1 on the fall-through path and 2 on the taken one
                    emit(i_type(12'd1, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
                    emit(j_type(21'd8, 5'd0));
                    emit(i_type(12'd2, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
                    store_slot(5'd3, taken ? 32'd2 : 32'd1,
                               $sformatf("branch f3=%0d pair %0d", k, p));
                end
            end
        end
        run_program("branches");
    endtask

    task automatic jump_links();
        logic [31:0] link;
        logic [31:0] target;
        start_program();
        link = cur_addr() + 32'd4;
        emit(j_type(21'd8, 5'd5));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        store_slot(5'd5, link, "jal link");
        // base + 5 lands one byte past the target
        target = cur_addr() + 32'd16;
        load_const(5'd7, target - 32'd4);
        link = cur_addr() + 32'd4;
        emit(i_type(12'd5, 5'd7, 3'b000, 5'd8, 7'b1100111));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        emit(u_type(20'd0, 5'd9, 7'b0010111));
        store_slot(5'd8, link, "jalr link");
        store_slot(5'd9, target, "jalr target pc");
        store_slot(5'd6, 32'd0, "skipped instructions");
        run_program("jumps");
    endtask

    task automatic memory_roundtrip();
        logic [31:0] words [4];
        start_program();
        for (int i = 0; i < 4; i++) begin
            words[i] = lfsr_bits(32);
            load_const(5'd10, words[i]);
            store_at(5'd10, 512 + 4 * i, words[i], "sw");
        end
        for (int i = 0; i < 4; i++) begin
            emit(i_type(12'(512 + 4 * i), 5'd31, 3'b010, 5'd11, OPC_LOAD));
            store_slot(5'd11, words[i], "lw round trip");
        end
        // last word is never written
        emit(i_type(12'd1020, 5'd31, 3'b010, 5'd12, OPC_LOAD));
        store_slot(5'd12, fill_word(255), "lw of untouched word");
        run_program("memory");
    endtask

    task automatic zero_register();
        logic [31:0] rnd;
        logic [31:0] pc_now;
        start_program();
        load_const(5'd1, lfsr_bits(32) | 32'd1);
        emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        emit(u_type(20'habcde, 5'd0, 7'b0110111));
        emit(r_type(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd0));
        emit(i_type(12'd0, 5'd31, 3'b010, 5'd0, OPC_LOAD));
        store_slot(5'd0, 32'd0, "x0 after writes");
        for (int i = 0; i < 2; i++) begin
            rnd = lfsr_bits(20);
            pc_now = cur_addr();
            emit(u_type(rnd[19:0], 5'd12, 7'b0010111));
            store_slot(5'd12, pc_now + {rnd[19:0], 12'b0}, "auipc");
        end
        run_program("x0 and auipc");
    endtask

    task automatic reset_and_halt();
        logic [31:0] marker;
        start_program();
        marker = lfsr_bits(32);
        load_const(5'd1, marker);
        store_slot(5'd1, marker, "store before halt");
        emit(EBREAK);
        // fetched only once halted is set and never written
        emit(s_type(12'd8, 5'd1, 5'd31));
        run_program("halt");
        // reset has to clear the halt left by the previous run
        start_program();
        store_slot(5'd0, 32'd0, "store after second reset");
        run_program("reset after halt");
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        lfsr_state = 32'h392c_6ea6;
        errors = 0;
        checks = 0;
        prog.delete();
        load_memories();
        arithmetic_ops();
        branch_paths();
        jump_links();
        memory_roundtrip();
        zero_register();
        reset_and_halt();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
src/core_pkg.sv
src/decode_if.sv
src/riscv_ifu.sv
src/riscv_idu.sv
src/riscv_regfile.sv
src/riscv_exu.sv
src/riscv_wbu.sv
src/riscv_core.sv
verification/core_tb.sv

/* Makefile */
TOP = core_tb

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
